// ==== common/sigmoid_pkg.sv ====
package sigmoid_pkg;

	// signed Q4.12
	typedef logic signed [15:0] sig_arg_t;

	// linear pieces of the approximation
	typedef enum logic [1:0] {
		seg_center,
		seg_inner,
		seg_outer,
		seg_saturate
	} sig_segment_e;

	// unsigned Q16.32
	typedef struct packed {
		logic [15:0] int_part;
		logic [31:0] frac;
	} sig_fixed_t;

	// same word seen as serial bytes or as a fixed-point value
	typedef union packed {
		logic [5:0][7:0] bytes;
		sig_fixed_t fixed;
	} sigmoid_result_u;

endpackage

// ==== common/sigmoid_settings.svh ====
`ifndef SIGMOID_SETTINGS_SVH
`define SIGMOID_SETTINGS_SVH

// serial bit period in clock cycles
`define SIGMOID_CLKS_PER_BIT 16

// argument bytes, high byte first
`define SIGMOID_IN_BYTES 2

// result bytes, low byte first
`define SIGMOID_OUT_BYTES 6

`endif

// ==== common/uart_pkg.sv ====
package uart_pkg;

	// byte from the receiver, valid is a one-cycle strobe
	typedef struct packed {
		logic valid;
		logic [7:0] data;
	} uart_rx_byte_t;

	// request to the transmitter, start is a one-cycle strobe
	typedef struct packed {
		logic start;
		logic [7:0] data;
	} uart_tx_req_t;

endpackage

// ==== hw/sigmoid_sequencer.sv ====
`include "sigmoid_settings.svh"

module sigmoid_sequencer import uart_pkg::*, sigmoid_pkg::*; (
	input logic clk,
	input logic reset,
	input uart_rx_byte_t rx_byte,
	output sig_arg_t arg,
	output logic arg_valid,
	input sigmoid_result_u result,
	input logic result_valid,
	output uart_tx_req_t tx_req,
	input logic busy
);

	localparam int IN_BYTES = `SIGMOID_IN_BYTES;
	localparam int OUT_BYTES = `SIGMOID_OUT_BYTES;
	localparam int RD_W = $clog2(IN_BYTES + 1);
	localparam int WR_W = $clog2(OUT_BYTES + 1);
	localparam logic [RD_W-1:0] RD_LAST = RD_W'(IN_BYTES - 1);
	localparam logic [WR_W-1:0] WR_DONE = WR_W'(OUT_BYTES);

	typedef enum logic [1:0] {
		idle,
		reading,
		converting,
		transmitting
	} seq_state_t;

	seq_state_t state;
	logic [RD_W-1:0] rd_cnt;
	logic [WR_W-1:0] wr_cnt;
	logic arg_valid_q;
	logic start_q;
	logic [7:0] tx_data_q;
	sig_arg_t arg_q;
	sigmoid_result_u result_q;
	logic take_byte;
	logic tx_ready;
	logic send_byte;

	assign take_byte = (state == idle || state == reading) && rx_byte.valid;
	// no start two cycles running, busy only rises after the first
	assign tx_ready = state == transmitting && !busy && !start_q;
	assign send_byte = tx_ready && wr_cnt != WR_DONE;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			rd_cnt <= '0;
			wr_cnt <= '0;
			arg_valid_q <= 1'b0;
			start_q <= 1'b0;
		end else begin
			arg_valid_q <= 1'b0;
			start_q <= 1'b0;
			unique case (state)
				idle, reading: begin
					if (take_byte) begin
						if (rd_cnt == RD_LAST) begin
							rd_cnt <= '0;
							arg_valid_q <= 1'b1;
							state <= converting;
						end else begin
							rd_cnt <= rd_cnt + 1'b1;
							state <= reading;
						end
					end
				end
				converting: begin
					if (result_valid)
						state <= transmitting;
				end
				transmitting: begin
					if (send_byte) begin
						start_q <= 1'b1;
						wr_cnt <= wr_cnt + 1'b1;
					end else if (tx_ready) begin
						// last stop bit is out
						wr_cnt <= '0;
						state <= idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take_byte)
			arg_q <= {arg_q[7:0], rx_byte.data};
		if (state == converting && result_valid)
			result_q <= result;
		if (send_byte)
			tx_data_q <= result_q.bytes[wr_cnt];
	end

	assign arg = arg_q;
	assign arg_valid = arg_valid_q;
	assign tx_req.start = start_q;
	assign tx_req.data = tx_data_q;

endmodule

// ==== hw/sigmoid_uart_top.sv ====
module sigmoid_uart_top import uart_pkg::*, sigmoid_pkg::*; (
	input logic clk,
	input logic reset,
	input logic rx,
	output logic tx
);

	uart_rx_byte_t rx_byte;
	sig_arg_t arg;
	logic arg_valid;
	sigmoid_result_u result;
	logic result_valid;
	uart_tx_req_t tx_req;
	logic busy;

	uart_rx uart_rx_instance1 (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.rx_byte(rx_byte)
	);

	sigmoid_sequencer sigmoid_sequencer_instance1 (
		.clk(clk),
		.reset(reset),
		.rx_byte(rx_byte),
		.arg(arg),
		.arg_valid(arg_valid),
		.result(result),
		.result_valid(result_valid),
		.tx_req(tx_req),
		.busy(busy)
	);

	sigmoid_pwl sigmoid_pwl_instance1 (
		.clk(clk),
		.reset(reset),
		.arg(arg),
		.arg_valid(arg_valid),
		.result(result),
		.result_valid(result_valid)
	);

	uart_tx uart_tx_instance1 (
		.clk(clk),
		.reset(reset),
		.tx_req(tx_req),
		.busy(busy),
		.tx(tx)
	);

endmodule

// ==== project.f ====
+incdir+common
common/uart_pkg.sv
common/sigmoid_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
sigmoid/sigmoid_pwl.sv
hw/sigmoid_sequencer.sv
hw/sigmoid_uart_top.sv
verif/tb_sigmoid_uart.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_sigmoid_uart -f project.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== sigmoid/sigmoid_pwl.sv ====
module sigmoid_pwl import sigmoid_pkg::*; (
	input logic clk,
	input logic reset,
	input sig_arg_t arg,
	input logic arg_valid,
	output sigmoid_result_u result,
	output logic result_valid
);

	// breakpoints 1, 2.375 and 5 in Q4.12
	localparam logic [15:0] BP_INNER = 16'd4096;
	localparam logic [15:0] BP_OUTER = 16'd9728;
	localparam logic [15:0] BP_SAT = 16'd20480;

	// offsets 0.5, 0.625 and 0.84375 as Q.32 fractions
	localparam logic [31:0] OFS_CENTER = 32'h8000_0000;
	localparam logic [31:0] OFS_INNER = 32'hA000_0000;
	localparam logic [31:0] OFS_OUTER = 32'hD800_0000;

	logic [15:0] mag_in;
	sig_segment_e seg_in;
	logic [31:0] mag_ext;
	sigmoid_result_u s2_next;

	logic s1_valid;
	logic s1_neg;
	logic [15:0] s1_mag;
	sig_segment_e s1_seg;
	logic s2_valid;
	logic s2_neg;
	sigmoid_result_u s2_val;

	// -32768 maps to 32768, still fits unsigned
	assign mag_in = arg[15] ? 16'(-arg) : 16'(arg);

	always_comb begin
		if (mag_in < BP_INNER)
			seg_in = seg_center;
		else if (mag_in < BP_OUTER)
			seg_in = seg_inner;
		else if (mag_in < BP_SAT)
			seg_in = seg_outer;
		else
			seg_in = seg_saturate;
	end

	// Q4.12 to Q.32 is a shift by 20, minus the slope shift
	assign mag_ext = {16'd0, s1_mag};

	always_comb begin
		s2_next = '0;
		unique case (s1_seg)
			seg_center: s2_next.fixed.frac = (mag_ext << 18) + OFS_CENTER;
			seg_inner: s2_next.fixed.frac = (mag_ext << 17) + OFS_INNER;
			seg_outer: s2_next.fixed.frac = (mag_ext << 15) + OFS_OUTER;
			seg_saturate: s2_next.fixed.int_part = 16'd1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			s1_valid <= arg_valid;
			s2_valid <= s1_valid;
			result_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_neg <= arg[15];
		s1_mag <= mag_in;
		s1_seg <= seg_in;
		s2_neg <= s1_neg;
		s2_val <= s2_next;
		// 1 - v lands in the fraction alone, since v is at least 0.5
		if (s2_neg) begin
			result.fixed.int_part <= 16'd0;
			result.fixed.frac <= 32'd0 - s2_val.fixed.frac;
		end else begin
			result <= s2_val;
		end
	end

endmodule

// ==== uart/uart_rx.sv ====
`include "sigmoid_settings.svh"

module uart_rx import uart_pkg::*; (
	input logic clk,
	input logic reset,
	input logic rx,
	output uart_rx_byte_t rx_byte
);

	localparam int CLKS_PER_BIT = `SIGMOID_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shreg;
	logic valid_q;
	logic fall;

	assign fall = rx_prev && !rx_sync;

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
			state <= rx_idle;
			cnt <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			valid_q <= 1'b0;
			cnt <= cnt + 1'b1;
			unique case (state)
				rx_idle: begin
					cnt <= '0;
					if (fall)
						state <= rx_start;
				end
				rx_start: begin
					// half a bit in, line must still be low
					if (cnt == HALF_LAST) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? rx_idle : rx_data;
					end
				end
				rx_data: begin
					if (cnt == BIT_LAST) begin
						cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end
				end
				rx_stop: begin
					// stop bit midpoint, level not checked
					if (cnt == BIT_LAST) begin
						valid_q <= 1'b1;
						state <= rx_idle;
					end
				end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (state == rx_data && cnt == BIT_LAST)
			shreg <= {rx_sync, shreg[7:1]};
	end

	assign rx_byte.valid = valid_q;
	assign rx_byte.data = shreg;

endmodule

// ==== uart/uart_tx.sv ====
`include "sigmoid_settings.svh"

module uart_tx import uart_pkg::*; (
	input logic clk,
	input logic reset,
	input uart_tx_req_t tx_req,
	output logic busy,
	output logic tx
);

	localparam int CLKS_PER_BIT = `SIGMOID_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [3:0] STOP_BIT = 4'd9;

	logic [CNT_W-1:0] cnt;
	logic [3:0] bit_idx;
	logic [8:0] shreg;
	logic accept;
	logic bit_end;

	assign accept = tx_req.start && !busy;
	assign bit_end = busy && cnt == BIT_LAST;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			tx <= 1'b1;
			cnt <= '0;
			bit_idx <= '0;
		end else if (accept) begin
			// start bit goes out right away
			busy <= 1'b1;
			tx <= 1'b0;
			cnt <= '0;
			bit_idx <= '0;
		end else if (bit_end) begin
			cnt <= '0;
			if (bit_idx == STOP_BIT) begin
				busy <= 1'b0;
			end else begin
				tx <= shreg[0];
				bit_idx <= bit_idx + 1'b1;
			end
		end else if (busy) begin
			cnt <= cnt + 1'b1;
		end
	end

	// data bits then stop, refilled with idle level
	always_ff @(posedge clk) begin
		if (accept)
			shreg <= {1'b1, tx_req.data};
		else if (bit_end)
			shreg <= {1'b1, shreg[8:1]};
	end

endmodule

// ==== verif/tb_sigmoid_uart.sv ====
`include "sigmoid_settings.svh"

module tb_sigmoid_uart;

	localparam int CLKS_PER_BIT = `SIGMOID_CLKS_PER_BIT;
	localparam int IN_BYTES = `SIGMOID_IN_BYTES;
	localparam int OUT_BYTES = `SIGMOID_OUT_BYTES;
	localparam int CLK_PERIOD = 8;
	localparam int RANDOM_PAIRS = 100;
	localparam int BOUNDARY_COUNT = 23;
	localparam int BURST_FRAMES = 8;
	localparam int FRAMES = 2 * RANDOM_PAIRS + BOUNDARY_COUNT + BURST_FRAMES;
	localparam longint BIT_TIME = longint'(CLKS_PER_BIT * CLK_PERIOD);
	// reset, quiet check, tail and up to three idle bits before each argument byte
	localparam longint GAP_ALLOWANCE = longint'(FRAMES * IN_BYTES * 3 + 80) * BIT_TIME;
	localparam longint TIMEOUT =
		2 * longint'(FRAMES * (IN_BYTES + OUT_BYTES) * 10) * BIT_TIME + GAP_ALLOWANCE;
	localparam longint ONE_Q12 = 64'd4096;
	localparam longint ONE_Q32 = 64'h1_0000_0000;

	logic clk = 1'b0;
	logic reset;
	logic rx;
	logic tx;
	logic [31:0] rng_state;
	logic [7:0] tx_bytes[$];

	// 0, 1, 2.375 and 5 with one lsb either side and both ends of the range
	int boundary_args [BOUNDARY_COUNT] = '{
		0, 1, -1,
		4095, 4096, 4097, -4095, -4096, -4097,
		9727, 9728, 9729, -9727, -9728, -9729,
		20479, 20480, 20481, -20479, -20480, -20481,
		-32768, 32767
	};

	sigmoid_uart_top i_dut (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.tx(tx)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// result in units of 2^-32 and magnitude in units of 2^-12
	function automatic logic [47:0] expected_sigmoid(input logic [15:0] x);
		longint m;
		longint v;
		m = x[15] ? 64'd65536 - longint'(x) : longint'(x);
		if (m < ONE_Q12)
			v = (m << 20) / 64'd4 + ONE_Q32 / 64'd2;
		else if (m < (64'd19 * ONE_Q12) / 64'd8)
			v = (m << 20) / 64'd8 + (64'd5 * ONE_Q32) / 64'd8;
		else if (m < 64'd5 * ONE_Q12)
			v = (m << 20) / 64'd32 + (64'd27 * ONE_Q32) / 64'd32;
		else
			v = ONE_Q32;
		if (x[15])
			v = ONE_Q32 - v;
		return 48'(v);
	endfunction

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	// all host tasks start and end one time unit after a rising edge
	task automatic idle_bits(input int n);
		if (n > 0) begin
			rx = 1'b1;
			repeat (n * CLKS_PER_BIT) @(posedge clk);
			#1;
		end
	endtask

	task automatic send_serial_byte(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx = frame[i];
			repeat (CLKS_PER_BIT) @(posedge clk);
			#1;
		end
	endtask

	task automatic receive_result(output logic [47:0] value);
		value = '0;
		while (tx_bytes.size() < OUT_BYTES)
			@(posedge clk);
		for (int i = 0; i < OUT_BYTES; i++)
			value[8*i +: 8] = tx_bytes.pop_front();
		// rest of the last stop bit
		repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);
		#1;
	endtask

	task automatic run_frame(input logic [15:0] x, input logic use_gaps,
			output logic [47:0] value);
		logic [31:0] r;
		for (int i = IN_BYTES - 1; i >= 0; i--) begin
			if (use_gaps) begin
				r = lcg_next();
				idle_bits(int'(r[17:16]));
			end
			send_serial_byte(x[8*i +: 8]);
		end
		// no result byte is out yet, so anything queued is extra from the last frame
		compare("tx byte count", 64'(tx_bytes.size()), 64'd0);
		receive_result(value);
	endtask

	// samples tx at bit midpoints on the falling clock edge
	initial begin : tx_monitor
		logic [7:0] data;
		@(negedge reset);
		forever begin
			@(negedge clk);
			if (tx === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				if (tx !== 1'b0) begin
					$display("tx start bit went high before its midpoint");
					stop_run();
				end
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					data[i] = tx;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (tx !== 1'b1) begin
					$display("tx stop bit was low");
					stop_run();
				end
				tx_bytes.push_back(data);
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT);
		$display("timeout, the DUT did not finish all frames in time");
		stop_run();
	end

	initial begin : main
		logic [47:0] value;
		logic [47:0] mirror_value;
		logic [31:0] r;
		logic [15:0] x;
		logic [15:0] mirror_x;
		rng_state = 32'ha530_f788;
		reset = 1'b1;
		rx = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		// quiet line
		repeat (40 * CLKS_PER_BIT) begin
			@(negedge clk);
			compare("tx", 64'(tx), 64'd1);
		end
		@(posedge clk);
		#1;

		// random x followed by -x
		for (int n = 0; n < RANDOM_PAIRS; n++) begin
			r = lcg_next();
			x = r[31:16];
			mirror_x = -x;
			run_frame(x, 1'b1, value);
			compare("result", 64'(value), 64'(expected_sigmoid(x)));
			run_frame(mirror_x, 1'b1, mirror_value);
			if (x != 16'h8000)
				compare("symmetry sum", 64'(value) + 64'(mirror_value), ONE_Q32);
			compare("result", 64'(mirror_value), 64'(expected_sigmoid(mirror_x)));
		end

		for (int i = 0; i < BOUNDARY_COUNT; i++) begin
			x = 16'(boundary_args[i]);
			run_frame(x, 1'b1, value);
			if (boundary_args[i] == 0)
				compare("result at zero", 64'(value), 64'h8000_0000);
			if (boundary_args[i] >= 20480)
				compare("saturated result", 64'(value), ONE_Q32);
			compare("result", 64'(value), 64'(expected_sigmoid(x)));
		end

		// next argument right at the end of the sixth stop bit
		for (int i = 0; i < BURST_FRAMES; i++) begin
			r = lcg_next();
			x = r[31:16];
			run_frame(x, 1'b0, value);
			compare("result", 64'(value), 64'(expected_sigmoid(x)));
		end

		repeat (20 * CLKS_PER_BIT) @(posedge clk);
		compare("tx byte count", 64'(tx_bytes.size()), 64'd0);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
